// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int data_w    = 8;
    localparam int instr_w   = 16;
    localparam int reg_count = 16;

    // Instruction field positions
    localparam int op_lsb  = 12;
    localparam int rd_lsb  = 8;
    localparam int rs1_lsb = 4;
    localparam int rs2_lsb = 0;

    typedef logic [3:0]        reg_addr_t;
    typedef logic [data_w-1:0] data_t;

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_shl  = 4'd6,
        op_shr  = 4'd7,
        op_ldi  = 4'd8,
        op_mul  = 4'd9,
        op_in   = 4'd10,
        op_out  = 4'd11,
        op_halt = 4'd15
    } opcode_t;

    typedef enum logic {
        unit_alu,
        unit_mul
    } unit_t;

endpackage

// ==== instr_decoder.sv ====
module instr_decoder import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [instr_w-1:0] instr,
    input  logic               instr_valid,
    input  logic               issue_take,
    output logic               stall,
    output logic               dec_valid,
    output opcode_t            dec_op,
    output unit_t              dec_unit,
    output reg_addr_t          dec_rd,
    output reg_addr_t          dec_rs1,
    output reg_addr_t          dec_rs2,
    output data_t              dec_imm,
    output logic               dec_write
);

    logic [3:0] op_code;
    opcode_t    next_op;
    logic       load;
    logic       release_entry;

    assign op_code = instr[op_lsb +: 4];

    // Unused codes fall back to nop
    always_comb begin
        if (op_code inside {4'd12, 4'd13, 4'd14}) begin
            next_op = op_nop;
        end else begin
            next_op = opcode_t'(op_code);
        end
    end

    // A halt stays parked in the register, so nothing gets in behind it
    assign release_entry = issue_take && (dec_op != op_halt);
    assign stall = dec_valid && !release_entry;
    assign load  = instr_valid && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= 1'b1;
        end else if (release_entry) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec_op    <= next_op;
            dec_unit  <= (next_op == op_mul) ? unit_mul : unit_alu;
            dec_rd    <= instr[rd_lsb +: 4];
            dec_rs1   <= instr[rs1_lsb +: 4];
            dec_rs2   <= instr[rs2_lsb +: 4];
            dec_imm   <= instr[7:0];
            dec_write <= !(next_op inside {op_nop, op_out, op_halt});
        end
    end

endmodule

// ==== issue_control.sv ====
module issue_control import cpu_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dec_valid,
    input  opcode_t                      dec_op,
    input  unit_t                        dec_unit,
    input  reg_addr_t                    dec_rd,
    input  reg_addr_t                    dec_rs1,
    input  reg_addr_t                    dec_rs2,
    input  data_t                        dec_imm,
    input  logic                         dec_write,
    input  logic                         rob_full,
    input  logic [$clog2(rob_depth)-1:0] alloc_tag,
    input  logic                         retire_valid,
    input  logic [$clog2(rob_depth)-1:0] retire_tag,
    input  data_t                        rs1_value,
    input  data_t                        rs2_value,
    input  logic [15:0]                  sw,
    output logic                         issue_take,
    output logic                         alloc,
    output reg_addr_t                    rs1_addr,
    output reg_addr_t                    rs2_addr,
    output logic                         alu_start,
    output logic                         mul_start,
    output opcode_t                      start_op,
    output data_t                        start_a,
    output data_t                        start_b,
    output logic [$clog2(rob_depth)-1:0] start_tag,
    output reg_addr_t                    start_rd,
    output logic                         start_write
);

    localparam int tag_w = $clog2(rob_depth);

    logic [reg_count-1:0] pending;
    logic [tag_w-1:0]     last_tag [reg_count];
    logic                 halted;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 src_busy;

    // Which sources an opcode actually reads
    assign uses_rs1 = dec_op inside {op_add, op_sub, op_and, op_or, op_xor,
                                     op_shl, op_shr, op_mul, op_out};
    assign uses_rs2 = dec_op inside {op_add, op_sub, op_and, op_or, op_xor,
                                     op_shl, op_shr, op_mul};
    assign src_busy = (uses_rs1 && pending[dec_rs1]) || (uses_rs2 && pending[dec_rs2]);

    assign issue_take = dec_valid && !rob_full && !src_busy && !halted;
    assign alloc      = issue_take;
    assign alu_start  = issue_take && (dec_unit == unit_alu);
    assign mul_start  = issue_take && (dec_unit == unit_mul);

    assign rs1_addr    = dec_rs1;
    assign rs2_addr    = dec_rs2;
    assign start_op    = dec_op;
    assign start_a     = (dec_op == op_in) ? sw[data_w-1:0] : rs1_value;
    assign start_b     = rs2_value;
    assign start_tag   = alloc_tag;
    assign start_rd    = dec_rd;
    assign start_write = dec_write;

    // Retire clears only the last writer's bit and a same-cycle issue wins
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            halted  <= 1'b0;
        end else begin
            for (int r = 0; r < reg_count; r++) begin
                if (retire_valid && pending[r] && (last_tag[r] == retire_tag)) begin
                    pending[r] <= 1'b0;
                end
            end
            if (issue_take && dec_write) begin
                pending[dec_rd] <= 1'b1;
            end
            if (issue_take && (dec_op == op_halt)) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_take && dec_write) begin
            last_tag[dec_rd] <= alloc_tag;
        end
    end

    // One unit per issue and only op_mul goes to the multiplier
    assert property (@(posedge clk) disable iff (rst)
        (alu_start || mul_start) |->
            (!(alu_start && mul_start) && (mul_start == (start_op == op_mul))));

endmodule

// ==== alu_unit.sv ====
module alu_unit import cpu_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alu_start,
    input  opcode_t                      start_op,
    input  data_t                        start_a,
    input  data_t                        start_b,
    input  data_t                        start_imm,
    input  logic [$clog2(rob_depth)-1:0] start_tag,
    input  reg_addr_t                    start_rd,
    input  logic                         start_write,
    output logic                         alu_done,
    output logic [$clog2(rob_depth)-1:0] alu_tag,
    output reg_addr_t                    alu_rd,
    output data_t                        alu_value,
    output logic                         alu_write
);

    data_t result;

    always_comb begin
        case (start_op)
            op_add:  result = start_a + start_b;
            op_sub:  result = start_a - start_b;
            op_and:  result = start_a & start_b;
            op_or:   result = start_a | start_b;
            op_xor:  result = start_a ^ start_b;
            op_shl:  result = start_a << start_b[2:0];
            op_shr:  result = start_a >> start_b[2:0];
            op_ldi:  result = start_imm;
            // in, out, nop and halt pass operand a
            default: result = start_a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_start;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_tag   <= start_tag;
            alu_rd    <= start_rd;
            alu_value <= result;
            alu_write <= start_write;
        end
    end

endmodule

// ==== mult_unit.sv ====
module mult_unit import cpu_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         mul_start,
    input  data_t                        start_a,
    input  data_t                        start_b,
    input  logic [$clog2(rob_depth)-1:0] start_tag,
    input  reg_addr_t                    start_rd,
    input  logic                         start_write,
    output logic                         mul_done,
    output logic [$clog2(rob_depth)-1:0] mul_tag,
    output reg_addr_t                    mul_rd,
    output data_t                        mul_value,
    output logic                         mul_write
);

    localparam int tag_w = $clog2(rob_depth);

    logic             s1_valid, s2_valid;
    data_t            s1_a, s1_b;
    logic [tag_w-1:0] s1_tag, s2_tag;
    reg_addr_t        s1_rd, s2_rd;
    logic             s1_write, s2_write;
    data_t            lo_full, hi_full;
    data_t            pp_lo;
    logic [3:0]       pp_hi;

    // Two nibble partial products, only the low byte matters
    assign lo_full = s1_a * {4'b0000, s1_b[3:0]};
    assign hi_full = s1_a * {4'b0000, s1_b[7:4]};

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            mul_done <= 1'b0;
        end else begin
            s1_valid <= mul_start;
            s2_valid <= s1_valid;
            mul_done <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_a      <= start_a;
        s1_b      <= start_b;
        s1_tag    <= start_tag;
        s1_rd     <= start_rd;
        s1_write  <= start_write;
        pp_lo     <= lo_full;
        pp_hi     <= hi_full[3:0];
        s2_tag    <= s1_tag;
        s2_rd     <= s1_rd;
        s2_write  <= s1_write;
        mul_value <= pp_lo + {pp_hi, 4'b0000};
        mul_tag   <= s2_tag;
        mul_rd    <= s2_rd;
        mul_write <= s2_write;
    end

endmodule

// ==== reorder_buffer.sv ====
module reorder_buffer import cpu_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc,
    input  logic                         alloc_is_out,
    input  logic                         alu_done,
    input  logic [$clog2(rob_depth)-1:0] alu_tag,
    input  reg_addr_t                    alu_rd,
    input  data_t                        alu_value,
    input  logic                         alu_write,
    input  logic                         mul_done,
    input  logic [$clog2(rob_depth)-1:0] mul_tag,
    input  reg_addr_t                    mul_rd,
    input  data_t                        mul_value,
    input  logic                         mul_write,
    output logic                         rob_full,
    output logic [$clog2(rob_depth)-1:0] alloc_tag,
    output logic                         retire_valid,
    output logic [$clog2(rob_depth)-1:0] retire_tag,
    output reg_addr_t                    retire_rd,
    output data_t                        retire_value,
    output logic                         retire_write,
    output data_t                        led
);

    localparam int tag_w = $clog2(rob_depth);

    logic [tag_w-1:0]     head;
    logic [tag_w-1:0]     tail;
    logic [tag_w:0]       count;
    logic [rob_depth-1:0] busy;
    logic [rob_depth-1:0] done;
    logic [rob_depth-1:0] write_q;
    logic [rob_depth-1:0] is_out_q;
    reg_addr_t            rd_q [rob_depth];
    data_t                value_q [rob_depth];

    assign rob_full  = (count == (tag_w + 1)'(rob_depth));
    assign alloc_tag = tail;

    // ========================================
    // Retire port, head of the queue
    // ========================================

    assign retire_valid = busy[head] && done[head];
    assign retire_tag   = head;
    assign retire_rd    = rd_q[head];
    assign retire_value = value_q[head];
    assign retire_write = write_q[head];

    // ========================================
    // Control state
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            busy  <= '0;
            done  <= '0;
            led   <= '0;
        end else begin
            if (retire_valid) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;
                if (is_out_q[head]) begin
                    led <= value_q[head];
                end
            end
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (alu_done) begin
                done[alu_tag] <= 1'b1;
            end
            if (mul_done) begin
                done[mul_tag] <= 1'b1;
            end
            case ({alloc, retire_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry payload, one write port per unit
    always_ff @(posedge clk) begin
        if (alloc) begin
            is_out_q[tail] <= alloc_is_out;
        end
        if (alu_done) begin
            rd_q[alu_tag]    <= alu_rd;
            value_q[alu_tag] <= alu_value;
            write_q[alu_tag] <= alu_write;
        end
        if (mul_done) begin
            rd_q[mul_tag]    <= mul_rd;
            value_q[mul_tag] <= mul_value;
            write_q[mul_tag] <= mul_write;
        end
    end

    assert property (@(posedge clk) disable iff (rst) alu_done |-> busy[alu_tag]);
    assert property (@(posedge clk) disable iff (rst) mul_done |-> busy[mul_tag]);
    assert property (@(posedge clk) disable iff (rst) alloc |-> !rob_full);

endmodule

// ==== reg_file.sv ====
module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      retire_valid,
    input  logic      retire_write,
    input  reg_addr_t retire_rd,
    input  data_t     retire_value,
    output data_t     rs1_value,
    output data_t     rs2_value
);

    data_t regs [reg_count];

    // Architectural state only changes at retire
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_valid && retire_write) begin
            regs[retire_rd] <= retire_value;
        end
    end

    assign rs1_value = regs[rs1_addr];
    assign rs2_value = regs[rs2_addr];

endmodule

// ==== cpu.sv ====
module cpu import cpu_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [instr_w-1:0] instr,
    input  logic               instr_valid,
    input  logic [15:0]        sw,
    output logic               stall,
    output data_t              led,
    output logic               retire_valid,
    output reg_addr_t          retire_rd,
    output data_t              retire_value,
    output logic               retire_write
);

    localparam int tag_w = $clog2(rob_depth);

    // ========================================
    // Decode and issue
    // ========================================

    logic             dec_valid, dec_write;
    opcode_t          dec_op;
    unit_t            dec_unit;
    reg_addr_t        dec_rd, dec_rs1, dec_rs2;
    data_t            dec_imm;
    logic             issue_take, alloc, rob_full;
    logic [tag_w-1:0] alloc_tag, retire_tag;
    reg_addr_t        rs1_addr, rs2_addr;
    data_t            rs1_value, rs2_value;

    // ========================================
    // Unit start and result buses
    // ========================================

    logic             alu_start, mul_start, start_write;
    opcode_t          start_op;
    data_t            start_a, start_b;
    logic [tag_w-1:0] start_tag;
    reg_addr_t        start_rd;
    logic             alu_done, alu_write, mul_done, mul_write;
    logic [tag_w-1:0] alu_tag, mul_tag;
    reg_addr_t        alu_rd, mul_rd;
    data_t            alu_value, mul_value;

    instr_decoder decoder_inst (.*);

    issue_control #(.rob_depth(rob_depth)) issue_inst (.*);

    // Immediate goes straight from the decoder, it is still held in the issue cycle
    alu_unit #(.rob_depth(rob_depth)) alu_inst (
        .start_imm(dec_imm),
        .*
    );

    mult_unit #(.rob_depth(rob_depth)) mul_inst (.*);

    reorder_buffer #(.rob_depth(rob_depth)) rob_inst (
        .alloc_is_out(dec_op == op_out),
        .*
    );

    reg_file regs_inst (.*);

endmodule

// ==== tb_cpu.sv ====
module tb_cpu import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_alu  = 60;
    localparam int n_mix  = 64;
    localparam int n_dep  = 50;
    localparam int n_io   = 24;
    localparam int n_halt = 20;
    localparam int limit_cycles = 200 * (n_alu + n_mix + n_dep + n_io + n_halt) + 1000;

    typedef struct packed {
        logic      is_out;
        logic      write;
        reg_addr_t rd;
        data_t     value;
    } retire_t;

    logic        clk;
    logic        rst;
    logic [15:0] instr;
    logic        instr_valid;
    logic [15:0] sw;
    logic        stall;
    data_t       led;
    logic        retire_valid;
    reg_addr_t   retire_rd;
    data_t       retire_value;
    logic        retire_write;

    data_t   model_regs [16];
    retire_t expected [$];
    int      error_count = 0;
    int      check_count = 0;
    int      sent_count = 0;
    int      retired_count = 0;
    int      test_count = 0;
    int      failed_tests = 0;
    int      test_errors = 0;
    logic    led_due = 1'b0;
    data_t   led_expected;

    cpu #(.rob_depth(8)) cpu_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: instructions stopped retiring after %0d cycles", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

    // ========================================
    // Model and checks
    // ========================================

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected_value);
        check_count++;
        if (actual !== expected_value) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected_value);
        end
    endtask

    task automatic model_accept(logic [15:0] word);
        data_t       a;
        data_t       b;
        logic [15:0] product;
        retire_t     e;
        a = model_regs[word[7:4]];
        b = model_regs[word[3:0]];
        product = a * b;
        e.rd = word[11:8];
        e.is_out = (word[15:12] == 4'd11);
        e.write = 1'b1;
        case (word[15:12])
            4'd1:  e.value = a + b;
            4'd2:  e.value = a - b;
            4'd3:  e.value = a & b;
            4'd4:  e.value = a | b;
            4'd5:  e.value = a ^ b;
            4'd6:  e.value = a << b[2:0];
            4'd7:  e.value = a >> b[2:0];
            4'd8:  e.value = word[7:0];
            4'd9:  e.value = product[7:0];
            4'd10: e.value = sw[7:0];
            // Out, nop and halt write no register
            default: begin
                e.write = 1'b0;
                e.value = a;
            end
        endcase
        if (e.write) begin
            model_regs[e.rd] = e.value;
        end
        expected.push_back(e);
    endtask

    // led is checked one cycle after an out retires
    initial begin
        retire_t e;
        forever begin
            @(negedge clk);
            if (rst) begin
                led_due = 1'b0;
            end else begin
                if (led_due) begin
                    check_value("led", led, led_expected);
                    led_due = 1'b0;
                end
                if (retire_valid) begin
                    retired_count++;
                    if (expected.size() == 0) begin
                        error_count++;
                        $display("Retire at %0t with no instruction outstanding", $time);
                    end else begin
                        e = expected.pop_front();
                        check_value("retire_write", retire_write, e.write);
                        if (e.write) begin
                            check_value("retire_rd", retire_rd, e.rd);
                        end
                        if (e.write || e.is_out) begin
                            check_value("retire_value", retire_value, e.value);
                        end
                        if (e.is_out) begin
                            led_due = 1'b1;
                            led_expected = e.value;
                        end
                    end
                end
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    function automatic logic [15:0] encode(opcode_t op, int rd, int rs1, int rs2);
        return {op, rd[3:0], rs1[3:0], rs2[3:0]};
    endfunction

    task automatic send(logic [15:0] word);
        @(negedge clk);
        instr = word;
        instr_valid = 1'b1;
        while (stall) begin
            @(negedge clk);
        end
        model_accept(word);
        sent_count++;
    endtask

    task automatic drain();
        @(negedge clk);
        instr_valid = 1'b0;
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
    endtask

    task automatic end_test(string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        int      rd;
        int      next_rd;
        opcode_t op;
        rst = 1'b1;
        instr = '0;
        instr_valid = 1'b0;
        sw = '0;
        void'($urandom(32'hc3a8_45a6));
        apply_reset();

        for (int i = 0; i < n_alu; i++) begin
            send(encode(opcode_t'($urandom_range(1, 8)), $urandom % 16, $urandom % 16,
                        $urandom % 16));
        end
        drain();
        end_test("alu_random");

        // Seed r0 to r7, then products go to r8..r15 and ALU work stays in r4..r7
        for (int i = 0; i < 8; i++) begin
            send(encode(op_ldi, i, $urandom % 16, $urandom % 16));
        end
        for (int i = 8; i < n_mix; i++) begin
            if ($urandom % 2) begin
                send(encode(op_mul, $urandom_range(8, 15), $urandom % 4, $urandom % 4));
            end else begin
                send(encode(opcode_t'($urandom_range(1, 8)), $urandom_range(4, 7),
                            $urandom_range(4, 7), $urandom_range(4, 7)));
            end
        end
        drain();
        end_test("mul_mixed");

        rd = $urandom % 16;
        for (int i = 0; i < n_dep; i++) begin
            op = ($urandom % 4 == 0) ? op_mul : opcode_t'($urandom_range(1, 7));
            next_rd = $urandom % 16;
            send(encode(op, next_rd, rd, $urandom % 16));
            rd = next_rd;
        end
        drain();
        check_value("retired_count", retired_count, sent_count);
        end_test("raw_chain");

        // sw stays put until every op_in of the round has retired
        for (int round = 0; round < n_io / 8; round++) begin
            sw = $urandom;
            rd = $urandom % 16;
            send(encode(op_in, rd, 0, 0));
            send(encode(op_out, 0, rd, 0));
            send(encode(op_in, (rd + 1) % 16, 0, 0));
            send(encode(op_xor, (rd + 2) % 16, rd, (rd + 1) % 16));
            send(encode(op_out, 0, (rd + 2) % 16, 0));
            send(encode(opcode_t'($urandom_range(1, 8)), $urandom % 16, $urandom % 16,
                        $urandom % 16));
            send(encode(op_out, 0, $urandom % 16, 0));
            send({4'd13, 12'($urandom)});
            drain();
        end
        end_test("in_out");

        send(encode(op_ldi, 3, 4'h5, 4'ha));
        send(encode(op_ldi, 12, 4'hc, 4'h3));
        send(encode(op_out, 0, 3, 0));
        send(encode(op_halt, 0, 0, 0));
        drain();
        // Must never be taken once halted
        @(negedge clk);
        instr = encode(op_ldi, 1, 1, 1);
        instr_valid = 1'b1;
        repeat (40) begin
            @(negedge clk);
            check_value("stall", stall, 1);
        end
        instr_valid = 1'b0;
        apply_reset();
        @(negedge clk);
        check_value("led", led, 0);
        check_value("stall", stall, 0);
        for (int r = 0; r < 16; r++) begin
            send(encode(op_out, 0, r, 0));
        end
        drain();
        end_test("halt_reset");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
cpu_pkg.sv
instr_decoder.sv
issue_control.sv
alu_unit.sv
mult_unit.sv
reorder_buffer.sv
reg_file.sv
cpu.sv
tb_cpu.sv
